// File: src/bitslice_pkg.sv
`default_nettype none

package bitslice_pkg;

  // bit slots per word period of the bit clock
  localparam int SLOTS  = 8;
  localparam int SLOT_W = 3;

  // word periods from sampling to use, counted in word registers
  localparam int TX_WORD_DLY = 1;
  localparam int RD_GATE_DLY = 2;

  // read-side FIFO
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = 4;

  // one data bit per slot
  typedef logic [SLOTS-1:0] dq_word_t;

  // one control bit per slot pair, used for t_b and rden
  typedef logic [SLOTS/2-1:0] quad_t;

  // receive FSM
  typedef enum logic {
    RX_IDLE,
    RX_BURST
  } rx_state_e;

endpackage : bitslice_pkg

`default_nettype wire

// File: src/slot_if.sv
`timescale 1ns/10ps
`default_nettype none

// slot phase and delayed fabric words, from the capture side to tx and rx
interface slot_if;

  logic [bitslice_pkg::SLOT_W-1:0] slot;
  logic                            last_slot;
  bitslice_pkg::dq_word_t          tx_word;
  bitslice_pkg::quad_t             tx_t_b;
  bitslice_pkg::quad_t             rd_en_word;

  modport src (
    output slot,
    output last_slot,
    output tx_word,
    output tx_t_b,
    output rd_en_word
  );

  modport tx (
    input slot,
    input tx_word,
    input tx_t_b
  );

  modport rx (
    input slot,
    input rd_en_word
  );

endinterface : slot_if

`default_nettype wire

// File: src/fabric_capture.sv
`timescale 1ns/10ps
`default_nettype none

module fabric_capture (
  input  logic                   i_o_clk_rd,
  input  logic                   rst,
  input  bitslice_pkg::dq_word_t i_wr_dq,
  input  bitslice_pkg::quad_t    i_t_b,
  input  bitslice_pkg::quad_t    i_rden,
  output logic                   o_div_clk,
  slot_if.src                    sif
);

  import bitslice_pkg::*;

  logic [SLOT_W-1:0] slot_q;

  // word delay lines, all stepping once per word period
  dq_word_t wr_pipe [TX_WORD_DLY];
  quad_t    tb_pipe [TX_WORD_DLY];
  quad_t    rd_pipe [RD_GATE_DLY];

  // free-running slot counter, reset value puts the first clock in slot 0
  always_ff @(posedge i_o_clk_rd or posedge rst) begin
    if (rst) begin
      slot_q <= SLOT_W'(SLOTS - 1);
    end else begin
      slot_q <= slot_q + 1'b1;
    end
  end

  assign sif.slot      = slot_q;
  assign sif.last_slot = (slot_q == SLOT_W'(SLOTS - 1));

  // divided clock, high for the first half of the word period
  assign o_div_clk = ~slot_q[SLOT_W-1];

  // sample at the edge that ends slot 7, then shift through the delay stages
  always_ff @(posedge i_o_clk_rd or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < TX_WORD_DLY; k++) begin
        wr_pipe[k] <= '0;
        tb_pipe[k] <= '0;
      end
      for (int k = 0; k < RD_GATE_DLY; k++) begin
        rd_pipe[k] <= '0;
      end
    end else if (sif.last_slot) begin
      wr_pipe[0] <= i_wr_dq;
      tb_pipe[0] <= i_t_b;
      rd_pipe[0] <= i_rden;
      for (int k = 1; k < TX_WORD_DLY; k++) begin
        wr_pipe[k] <= wr_pipe[k-1];
        tb_pipe[k] <= tb_pipe[k-1];
      end
      for (int k = 1; k < RD_GATE_DLY; k++) begin
        rd_pipe[k] <= rd_pipe[k-1];
      end
    end
  end

  assign sif.tx_word    = wr_pipe[TX_WORD_DLY-1];
  assign sif.tx_t_b     = tb_pipe[TX_WORD_DLY-1];
  assign sif.rd_en_word = rd_pipe[RD_GATE_DLY-1];

  // last_slot marks slot 7 only, and the counter wraps to 0 after it
  a_last_slot: assert property (@(posedge i_o_clk_rd) disable iff (rst)
    sif.last_slot |-> (sif.slot == SLOT_W'(SLOTS - 1)) ##1 (sif.slot == '0))
    else $error("last_slot out of step with slot counter");

endmodule : fabric_capture

`default_nettype wire

// File: src/tx_serializer.sv
`timescale 1ns/10ps
`default_nettype none

module tx_serializer (
  input  logic i_o_clk_rd,
  input  logic rst,
  slot_if.tx   sif,
  output logic o_q,
  output logic o_t
);

  import bitslice_pkg::*;

  // word and t_b held for the period being driven on the pad
  dq_word_t          word_hold;
  quad_t             tb_hold;
  logic [SLOT_W-1:0] nxt_slot;

  // outputs are registered, so each edge loads the bit for the next slot
  assign nxt_slot = sif.slot + 1'b1;

  always_ff @(posedge i_o_clk_rd or posedge rst) begin
    if (rst) begin
      word_hold <= '0;
      tb_hold   <= '0;
      o_q       <= 1'b0;
      o_t       <= 1'b1;
    end else if (sif.slot == SLOT_W'(SLOTS - 1)) begin
      // period boundary: take the new word and drive its slot 0 bit
      word_hold <= sif.tx_word;
      tb_hold   <= sif.tx_t_b;
      o_q       <= sif.tx_word[0];
      o_t       <= ~sif.tx_t_b[0];
    end else begin
      o_q <= word_hold[nxt_slot];
      // driver on (t low) for each slot pair with t_b set
      o_t <= ~tb_hold[nxt_slot[SLOT_W-1:1]];
    end
  end

  // tristate only changes on a slot pair boundary
  a_t_pair: assert property (@(posedge i_o_clk_rd) disable iff (rst)
    sif.slot[0] |-> (o_t == $past(o_t)))
    else $error("o_t changed inside a slot pair");

endmodule : tx_serializer

`default_nettype wire

// File: src/rx_deserializer.sv
`timescale 1ns/10ps
`default_nettype none

module rx_deserializer (
  input  logic                   i_o_clk_rd,
  input  logic                   rst,
  slot_if.rx                     sif,
  input  logic                   i_iob_d,
  input  logic                   i_dqs,
  output logic                   o_push,
  output bitslice_pkg::dq_word_t o_push_word
);

  import bitslice_pkg::*;

  rx_state_e         state;
  quad_t             gate_word;
  logic              gate;
  logic              dqs_q;
  logic              dqs_edge;
  logic              capture;
  logic [SLOT_W-1:0] bit_cnt;
  logic              push_q;
  dq_word_t          shift_q;

  // per-slot gate, one rden bit covers two slots
  assign gate     = gate_word[sif.slot[SLOT_W-1:1]];
  assign dqs_edge = i_dqs ^ dqs_q;
  assign capture  = gate & dqs_edge;

  always_ff @(posedge i_o_clk_rd or posedge rst) begin
    if (rst) begin
      state     <= RX_IDLE;
      gate_word <= '0;
      dqs_q     <= 1'b0;
      bit_cnt   <= '0;
      push_q    <= 1'b0;
    end else begin
      dqs_q  <= i_dqs;
      push_q <= 1'b0;
      // gate word follows the delayed rden, one period later
      if (sif.slot == SLOT_W'(SLOTS - 1)) begin
        gate_word <= sif.rd_en_word;
      end
      case (state)
        RX_IDLE: begin
          if (capture) begin
            state   <= RX_BURST;
            bit_cnt <= SLOT_W'(1);
          end
        end
        RX_BURST: begin
          if (!capture) begin
            // gap in the burst, drop the partial word
            state   <= RX_IDLE;
            bit_cnt <= '0;
          end else if (bit_cnt == SLOT_W'(SLOTS - 1)) begin
            push_q  <= 1'b1;
            state   <= RX_IDLE;
            bit_cnt <= '0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // first captured bit ends up in bit 0
  always_ff @(posedge i_o_clk_rd) begin
    if (capture) begin
      shift_q <= {i_iob_d, shift_q[SLOTS-1:1]};
    end
  end

  assign o_push      = push_q;
  assign o_push_word = shift_q;

  // a word takes eight captures, so pushes can never be back to back
  a_push_gap: assert property (@(posedge i_o_clk_rd) disable iff (rst)
    o_push |=> !o_push)
    else $error("push strobe high on two consecutive clocks");

endmodule : rx_deserializer

`default_nettype wire

// File: src/rx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module rx_fifo (
  input  logic                   i_o_clk_rd,
  input  logic                   rst,
  input  logic                   i_push,
  input  bitslice_pkg::dq_word_t i_push_word,
  input  logic                   i_fifo_rden,
  output bitslice_pkg::dq_word_t o_rd_dq,
  output logic                   o_fifo_empty
);

  import bitslice_pkg::*;

  dq_word_t           mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW-1:0] rd_next;
  logic [FIFO_AW:0]   count;
  logic [FIFO_AW:0]   count_next;
  logic               push_ok;
  logic               pop_ok;

  // full drops the push, empty ignores the pop
  assign push_ok = i_push && (count != (FIFO_AW+1)'(FIFO_DEPTH));
  assign pop_ok  = i_fifo_rden && (count != '0);
  assign rd_next = rd_ptr + FIFO_AW'(pop_ok);

  always_comb begin
    case ({push_ok, pop_ok})
      2'b10:   count_next = count + 1'b1;
      2'b01:   count_next = count - 1'b1;
      default: count_next = count;
    endcase
  end

  always_ff @(posedge i_o_clk_rd) begin
    if (push_ok) begin
      mem[wr_ptr] <= i_push_word;
    end
  end

  always_ff @(posedge i_o_clk_rd or posedge rst) begin
    if (rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      o_fifo_empty <= 1'b1;
      o_rd_dq      <= '0;
    end else begin
      wr_ptr       <= wr_ptr + FIFO_AW'(push_ok);
      rd_ptr       <= rd_next;
      count        <= count_next;
      o_fifo_empty <= (count_next == '0);
      // next head, the incoming word bypasses the array when nothing else is left
      if (count_next != '0) begin
        if (push_ok && (count == (FIFO_AW+1)'(pop_ok))) begin
          o_rd_dq <= i_push_word;
        end else begin
          o_rd_dq <= mem[rd_next];
        end
      end
    end
  end

  a_count_max: assert property (@(posedge i_o_clk_rd) disable iff (rst)
    count <= (FIFO_AW+1)'(FIFO_DEPTH))
    else $error("fifo count above depth");

endmodule : rx_fifo

`default_nettype wire

// File: src/bitslice_top.sv
`timescale 1ns/10ps
`default_nettype none

module bitslice_top (
  input  logic                   i_o_clk_rd,
  input  logic                   rst,
  input  bitslice_pkg::dq_word_t i_wr_dq,
  input  bitslice_pkg::quad_t    i_t_b,
  input  bitslice_pkg::quad_t    i_rden,
  input  logic                   i_iob_d,
  input  logic                   i_dqs,
  input  logic                   i_fifo_rden,
  output logic                   o_q,
  output logic                   o_t,
  output logic                   o_div_clk,
  output bitslice_pkg::dq_word_t o_rd_dq,
  output logic                   o_fifo_empty
);

  import bitslice_pkg::*;

  logic     push;
  dq_word_t push_word;

  slot_if u_slot_if ();

  fabric_capture u_fabric_capture (
    .i_o_clk_rd (i_o_clk_rd),
    .rst        (rst),
    .i_wr_dq    (i_wr_dq),
    .i_t_b      (i_t_b),
    .i_rden     (i_rden),
    .o_div_clk  (o_div_clk),
    .sif        (u_slot_if.src)
  );

  tx_serializer u_tx_serializer (
    .i_o_clk_rd (i_o_clk_rd),
    .rst        (rst),
    .sif        (u_slot_if.tx),
    .o_q        (o_q),
    .o_t        (o_t)
  );

  rx_deserializer u_rx_deserializer (
    .i_o_clk_rd  (i_o_clk_rd),
    .rst         (rst),
    .sif         (u_slot_if.rx),
    .i_iob_d     (i_iob_d),
    .i_dqs       (i_dqs),
    .o_push      (push),
    .o_push_word (push_word)
  );

  rx_fifo u_rx_fifo (
    .i_o_clk_rd   (i_o_clk_rd),
    .rst          (rst),
    .i_push       (push),
    .i_push_word  (push_word),
    .i_fifo_rden  (i_fifo_rden),
    .o_rd_dq      (o_rd_dq),
    .o_fifo_empty (o_fifo_empty)
  );

endmodule : bitslice_top

`default_nettype wire

// File: bench/tb_bitslice.sv
`timescale 1ns/10ps
`default_nettype none

module tb_bitslice;

  import bitslice_pkg::*;

  localparam time CLK_PERIOD = 100ns;
  localparam time DRIVE_DLY  = 10ns;
  localparam int  WAIT_LIMIT = 4 * SLOTS;

  logic     clk;
  logic     rst;
  dq_word_t wr_dq;
  quad_t    t_b;
  quad_t    rden;
  logic     iob_d;
  logic     dqs;
  logic     fifo_rden;
  logic     q;
  logic     t;
  logic     div_clk;
  dq_word_t rd_dq;
  logic     fifo_empty;
  int       errors;
  int       timeouts;

  bitslice_top i_dut (
    .i_o_clk_rd   (clk),
    .rst          (rst),
    .i_wr_dq      (wr_dq),
    .i_t_b        (t_b),
    .i_rden       (rden),
    .i_iob_d      (iob_d),
    .i_dqs        (dqs),
    .i_fifo_rden  (fifo_rden),
    .o_q          (q),
    .o_t          (t),
    .o_div_clk    (div_clk),
    .o_rd_dq      (rd_dq),
    .o_fifo_empty (fifo_empty)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
      else begin
        errors++;
        $display("error: %s expected 0x%0h got 0x%0h at %0t", name, exp, act, $time);
      end
  endtask

  // one clock, then on to the drive point; the data pad idles with filler
  task automatic step();
    @(posedge clk);
    #(DRIVE_DLY);
    iob_d = 1'($urandom);
  endtask

  // rising edge of the divided clock marks slot 0
  task automatic align_period();
    logic prev;
    int   n;
    n    = 0;
    prev = div_clk;
    step();
    while (!(div_clk && !prev) && (n < WAIT_LIMIT)) begin
      prev = div_clk;
      step();
      n++;
    end
    assert (n < WAIT_LIMIT)
      else begin
        timeouts++;
        $display("timeout while waiting for the start of a word period at %0t", $time);
      end
  endtask

  task automatic wait_not_empty();
    int n;
    n = 0;
    while (fifo_empty && (n < WAIT_LIMIT)) begin
      step();
      n++;
    end
    assert (!fifo_empty)
      else begin
        timeouts++;
        $display("timeout while waiting for a word in the FIFO at %0t", $time);
      end
  endtask

  task automatic pop();
    fifo_rden = 1'b1;
    step();
    fifo_rden = 1'b0;
  endtask

  // word sampled in period P goes out on the pad in period P+TX_WORD_DLY+1
  task automatic run_write(input dq_word_t data, input quad_t tb, input dq_word_t exp_t);
    align_period();
    wr_dq = data;
    t_b   = tb;
    for (int p = 0; p <= TX_WORD_DLY; p++) begin
      align_period();
      wr_dq = dq_word_t'($urandom);
      t_b   = quad_t'($urandom);
    end
    for (int s = 0; s < SLOTS; s++) begin
      check_val("o_q", data[s], q);
      check_val("o_t", exp_t[s], t);
      // divided clock is high for slots 0 to 3
      check_val("o_div_clk", (s < SLOTS / 2), div_clk);
      step();
    end
  endtask

  // rden sampled in period P opens the gate in period P+RD_GATE_DLY+1
  task automatic run_burst(input dq_word_t data, input quad_t en);
    align_period();
    rden = en;
    for (int p = 0; p <= RD_GATE_DLY; p++) begin
      align_period();
      rden = '0;
    end
    // strobe toggles every slot, one data bit per edge
    for (int s = 0; s < SLOTS; s++) begin
      dqs   = ~dqs;
      iob_d = data[s];
      step();
    end
  endtask

  task automatic run_read(input dq_word_t data, input quad_t en, input dq_word_t exp);
    run_burst(data, en);
    wait_not_empty();
    check_val("o_rd_dq", exp, rd_dq);
    pop();
    check_val("o_fifo_empty", 1, fifo_empty);
  endtask

  task automatic run_partial(input dq_word_t data, input quad_t en);
    run_burst(data, en);
    for (int n = 0; n < 2 * SLOTS; n++) begin
      check_val("o_fifo_empty", 1, fifo_empty);
      step();
    end
  endtask

  // bursts carry base, base+1, ... and only the first kept words fit
  task automatic run_overflow(input dq_word_t base, input int bursts, input int kept);
    int n;
    n = 0;
    for (int b = 0; b < bursts; b++) begin
      run_burst(base + dq_word_t'(b), '1);
    end
    // last push lands before the first pop
    step();
    while (!fifo_empty && (n < FIFO_DEPTH + 2)) begin
      check_val("o_rd_dq", base + dq_word_t'(n), rd_dq);
      pop();
      n++;
    end
    check_val("words popped", kept, n);
    pop();
    check_val("o_fifo_empty", 1, fifo_empty);
  endtask

  initial begin
    int              fd;
    int              cnt;
    logic [8*96-1:0] line;
    logic [8*16-1:0] op;
    logic [31:0]     a;
    logic [31:0]     b;
    logic [31:0]     c;
    errors    = 0;
    timeouts  = 0;
    rst       = 1'b1;
    wr_dq     = '0;
    t_b       = '0;
    rden      = '0;
    iob_d     = 1'b0;
    dqs       = 1'b0;
    fifo_rden = 1'b0;
    repeat (3) @(posedge clk);
    #(DRIVE_DLY);
    rst = 1'b0;
    check_val("o_t", 1, t);
    check_val("o_q", 0, q);
    check_val("o_fifo_empty", 1, fifo_empty);
    void'($urandom(32'h26f4));
    fd = $fopen("bench/bitslice_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the test records file bench/bitslice_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = '0;
        op   = '0;
        cnt  = $fgets(line, fd);
        cnt  = $sscanf(line, "%s %h %h %h", op, a, b, c);
        if ((cnt == 4) && (op != "#")) begin
          case (op)
            "write":    run_write(a[7:0], b[3:0], c[7:0]);
            "read":     run_read(a[7:0], b[3:0], c[7:0]);
            "partial":  run_partial(a[7:0], b[3:0]);
            "overflow": run_overflow(a[7:0], b, c);
            default: begin
              errors++;
              $display("unknown keyword in a test record: %0s", op);
            end
          endcase
        end
      end
      $fclose(fd);
    end
    $display("checks done, %0d errors, %0d timeouts", errors, timeouts);
    if ((errors == 0) && (timeouts == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule : tb_bitslice

`default_nettype wire

// File: bench/bitslice_tests.txt
# keyword, then three hex columns
#   write    : wr_dq, t_b, expected o_t per slot (bit n is slot n)
#   read     : i_iob_d byte, rden, expected o_rd_dq
#   partial  : i_iob_d byte, rden, unused
#   overflow : first byte, number of bursts, number of words kept
write a5 f 00
write 3c 5 cc
write 81 a 33
write 00 0 ff
write 6e 6 c3
write d2 9 3c
read 5a f 5a
read c3 f c3
read 01 f 01
partial 96 3 00
read 0f f 0f
partial 6b c 00
read e7 f e7
overflow 40 12 10
read 99 f 99

// File: all.f
src/bitslice_pkg.sv
src/slot_if.sv
src/fabric_capture.sv
src/tx_serializer.sv
src/rx_deserializer.sv
src/rx_fifo.sv
src/bitslice_top.sv
bench/tb_bitslice.sv

// File: Bender.yml
package:
  name: bitslice

sources:
  - src/bitslice_pkg.sv
  - src/slot_if.sv
  - src/fabric_capture.sv
  - src/tx_serializer.sv
  - src/rx_deserializer.sv
  - src/rx_fifo.sv
  - src/bitslice_top.sv
  - target: test
    files:
      - bench/tb_bitslice.sv
